/* common/usbAudioPkg.sv */
`default_nettype none

package usbAudioPkg;

   // ------------------------------
   // Control requests
   // ------------------------------
   typedef enum logic [7:0] {
      SET_CUR           = 8'h01,   // Audio class
      SET_ADDRESS       = 8'h05,
      GET_DESCRIPTOR    = 8'h06,   // Always stalled here
      SET_CONFIGURATION = 8'h09,
      SET_INTERFACE     = 8'h0B,
      GET_CUR           = 8'h81,   // Audio class
      GET_MIN           = 8'h82,
      GET_MAX           = 8'h83,
      GET_RES           = 8'h84
   } requestCodeT;

   typedef enum logic [3:0] {
      idle,
      getRequest, getValueLow, getValueHigh,   // One state per SETUP byte
      getIndexLow, getIndexHigh,
      getLengthLow, getLengthHigh,
      getEoP,
      setAddress, setConfiguration, setInterface,
      setControl, getControl, sendControl
   } controlStateT;

   // Feature unit addressing
   localparam logic [7:0]  MUTE_CONTROL        = 8'h01;
   localparam logic [7:0]  VOLUME_CONTROL      = 8'h02;
   localparam logic [15:0] FEATURE_UNIT_TARGET = 16'h0002;   // Unit 0, interface 2
   localparam logic [15:0] STREAM_INTERFACE    = 16'd1;

   // Volume in 1/256 dB steps
   localparam logic [15:0] VOLUME_RESET = 16'h1400;   // 20 dB
   localparam logic [15:0] VOLUME_MIN   = 16'h0000;
   localparam logic [15:0] VOLUME_MAX   = 16'h7FFF;
   localparam logic [15:0] VOLUME_RES   = 16'h0001;

   // ------------------------------
   // Streaming path
   // ------------------------------
   localparam int FIFO_ADDR_BITS = 10;
   localparam logic [FIFO_ADDR_BITS-1:0] FIFO_PREFILL = 10'd384;   // 2 ms of stereo
   localparam logic [31:0] SAMPLE_INCREMENT = 32'h0041_8937;      // 1000 clocks per sample
   localparam logic [9:0]  PWM_MIDPOINT     = 10'd500;
   localparam logic [3:0]  AUDIO_ENDPOINT   = 4'd1;

endpackage

`default_nettype wire

/* control/setupControl.sv */
`default_nettype none

module setupControl (
   input  wire         USB_Clk,
   input  wire         softReset,
   input  wire  [3:0]  endpoint,
   input  wire         outSetup,
   input  wire         outSoP,
   input  wire         outEoP,
   input  wire  [7:0]  outData,
   input  wire         outValid,
   input  wire         inAck,
   input  wire         error,
   input  wire         inWaitRequest,
   input  wire  [15:0] getValue,
   input  wire         getValid,
   input  wire         lastByte,
   output logic [6:0]  address,
   output logic        stall,
   output logic        inReady,
   output logic        writeMute,
   output logic        writeVolumeLeft,
   output logic        writeVolumeRight,
   output logic        writeAltSetting,
   output logic [15:0] writeValue,
   output logic        loadResponse,
   output logic [15:0] responseValue,
   output logic [1:0]  responseSize,
   output usbAudioPkg::requestCodeT requestCode,
   output logic [7:0]  controlSelect,
   output logic [7:0]  channelSelect,
   output logic [15:0] target
);
   import usbAudioPkg::*;

   controlStateT state;
   controlStateT dispatchState;
   logic [1:0]   requestType;     // bmRequestType[6:5]
   logic [15:0]  value;           // wValue
   logic [15:0]  index;           // wIndex
   logic [15:0]  dataWord;        // SET_CUR payload
   logic         dataStageDone;
   logic         muteSel;
   logic         leftSel;
   logic         rightSel;
   logic         setState;
   logic         commit;

   assign controlSelect = value[15:8];
   assign channelSelect = value[7:0];
   assign target        = index;

   // ------------------------------
   // Feature unit decode
   // ------------------------------
   assign muteSel  = (target == FEATURE_UNIT_TARGET) && (controlSelect == MUTE_CONTROL)
                     && (channelSelect == 8'd0);
   assign leftSel  = (target == FEATURE_UNIT_TARGET) && (controlSelect == VOLUME_CONTROL)
                     && (channelSelect == 8'd1);
   assign rightSel = (target == FEATURE_UNIT_TARGET) && (controlSelect == VOLUME_CONTROL)
                     && (channelSelect == 8'd2);

   // Registers change on the status acknowledge
   assign commit           = (state == setControl) && dataStageDone && inAck;
   assign writeMute        = commit && muteSel;
   assign writeVolumeLeft  = commit && leftSel;
   assign writeVolumeRight = commit && rightSel;
   assign writeAltSetting  = (state == setInterface) && inAck && (index == STREAM_INTERFACE);
   assign writeValue       = (state == setInterface) ? value : dataWord;

   // Zero length status for set requests
   assign setState = (state == setAddress) || (state == setConfiguration)
                     || (state == setInterface) || (state == setControl);
   assign loadResponse  = (setState && !inReady) || ((state == getControl) && getValid);
   assign responseValue = getValue;
   assign responseSize  = (state != getControl)          ? 2'd0 :
                          (controlSelect == MUTE_CONTROL) ? 2'd1 : 2'd2;

   // Request dispatch
   always_comb begin
      dispatchState = idle;   // Unsupported, stalls
      if (requestType == 2'b00) begin   // Standard
         case (requestCode)
            SET_ADDRESS:       dispatchState = setAddress;
            SET_CONFIGURATION: dispatchState = setConfiguration;
            SET_INTERFACE:     dispatchState = setInterface;
            GET_DESCRIPTOR:    dispatchState = idle;   // No descriptor ROM
            default:           dispatchState = idle;
         endcase
      end else if (requestType == 2'b01) begin   // Class
         case (requestCode)
            SET_CUR:                            dispatchState = setControl;
            GET_CUR, GET_MIN, GET_MAX, GET_RES: dispatchState = getControl;
            default:                            dispatchState = idle;
         endcase
      end
   end

   // ------------------------------
   // Control FSM
   // ------------------------------
   always_ff @(posedge USB_Clk) begin
      if (softReset) begin
         state         <= idle;
         address       <= '0;
         stall         <= 1'b0;
         inReady       <= 1'b0;
         dataStageDone <= 1'b0;
      end else if (outValid && outSoP && outSetup) begin   // SETUP overrides everything
         requestType   <= outData[6:5];
         stall         <= 1'b0;
         inReady       <= 1'b0;
         dataStageDone <= 1'b0;
         state         <= getRequest;
      end else if (endpoint == 4'd0) begin
         case (state)
            getRequest: if (outValid) begin
               requestCode <= requestCodeT'(outData);
               state       <= getValueLow;
            end
            getValueLow: if (outValid) begin
               value[7:0] <= outData;
               state      <= getValueHigh;
            end
            getValueHigh: if (outValid) begin
               value[15:8] <= outData;
               state       <= getIndexLow;
            end
            getIndexLow: if (outValid) begin
               index[7:0] <= outData;
               state      <= getIndexHigh;
            end
            getIndexHigh: if (outValid) begin
               index[15:8] <= outData;
               state       <= getLengthLow;
            end
            // wLength unused, responses are fixed size
            getLengthLow:  if (outValid) state <= getLengthHigh;
            getLengthHigh: if (outValid) state <= getEoP;
            getEoP: if (outValid && outEoP) begin
               state <= dispatchState;
               if (dispatchState == idle) stall <= 1'b1;
            end
            setAddress, setConfiguration, setInterface: begin
               if (inAck) begin
                  inReady <= 1'b0;
                  state   <= idle;
                  if (state == setAddress) address <= value[6:0];
               end else begin
                  inReady <= 1'b1;   // Status IN
               end
            end
            setControl: begin
               if (inAck) begin
                  inReady <= 1'b0;
                  state   <= idle;
               end else begin
                  inReady <= 1'b1;
                  if (outValid && outEoP) begin
                     dataStageDone <= 1'b1;
                     if (!(muteSel || leftSel || rightSel)) begin   // Wrong target
                        stall   <= 1'b1;
                        inReady <= 1'b0;
                        state   <= idle;
                     end
                  end else if (outValid) begin
                     dataWord <= {outData, dataWord[15:8]};   // LSB first
                  end
               end
            end
            getControl: begin
               dataStageDone <= 1'b0;
               if (getValid) begin
                  inReady <= 1'b1;
                  state   <= sendControl;
               end else begin
                  stall <= 1'b1;
                  state <= idle;
               end
            end
            sendControl: begin
               if (outValid && outEoP) begin   // Status OUT ends the transfer
                  inReady <= 1'b0;
                  state   <= idle;
               end else if (inReady) begin
                  if (!inWaitRequest && lastByte) inReady <= 1'b0;
               end else if (inAck) begin
                  dataStageDone <= 1'b1;
               end else if (error && !dataStageDone) begin
                  state <= getControl;   // Resend the data packet
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* control/featureUnitRegs.sv */
`default_nettype none

module featureUnitRegs (
   input  wire         USB_Clk,
   input  wire         softReset,
   input  wire         writeMute,
   input  wire         writeVolumeLeft,
   input  wire         writeVolumeRight,
   input  wire         writeAltSetting,
   input  wire  [15:0] writeValue,
   input  wire usbAudioPkg::requestCodeT requestCode,
   input  wire  [7:0]  controlSelect,
   input  wire  [7:0]  channelSelect,
   input  wire  [15:0] target,
   output logic        mute,
   output logic        altSetting,
   output logic [15:0] getValue,
   output logic        getValid
);
   import usbAudioPkg::*;

   logic [15:0] volumeLeft;    // Two's complement, 1/256 dB
   logic [15:0] volumeRight;

   always_ff @(posedge USB_Clk) begin
      if (softReset) begin
         mute        <= 1'b0;
         altSetting  <= 1'b0;   // Zero bandwidth, no sound
         volumeLeft  <= VOLUME_RESET;
         volumeRight <= VOLUME_RESET;
      end else begin
         if (writeMute)        mute        <= writeValue[8];   // Single byte lands high
         if (writeVolumeLeft)  volumeLeft  <= writeValue;
         if (writeVolumeRight) volumeRight <= writeValue;
         if (writeAltSetting)  altSetting  <= writeValue[0];
      end
   end

   // GET value lookup
   always_comb begin
      getValue = 16'h0000;
      getValid = 1'b0;
      if (target == FEATURE_UNIT_TARGET) begin
         if ((controlSelect == MUTE_CONTROL) && (channelSelect == 8'd0)
             && (requestCode == GET_CUR)) begin
            getValue = {15'd0, mute};
            getValid = 1'b1;
         end else if ((controlSelect == VOLUME_CONTROL)
                      && ((channelSelect == 8'd1) || (channelSelect == 8'd2))) begin
            getValid = 1'b1;
            case (requestCode)
               GET_CUR: getValue = (channelSelect == 8'd1) ? volumeLeft : volumeRight;
               GET_MIN: getValue = VOLUME_MIN;
               GET_MAX: getValue = VOLUME_MAX;
               GET_RES: getValue = VOLUME_RES;
               default: getValid = 1'b0;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* control/inResponder.sv */
`default_nettype none

module inResponder (
   input  wire         USB_Clk,
   input  wire         softReset,
   input  wire         loadResponse,
   input  wire  [15:0] responseValue,
   input  wire  [1:0]  responseSize,
   input  wire         inReady,
   input  wire         inWaitRequest,
   input  wire         inAck,
   output logic [7:0]  inData,
   output logic        inZeroLength,
   output logic        inSequence,
   output logic        lastByte
);
   logic [15:0] shiftReg;
   logic [1:0]  size;
   logic [1:0]  count;    // Bytes already taken
   logic        take;

   assign take         = inReady && !inWaitRequest;
   assign inData       = shiftReg[7:0];   // LSB first
   assign inZeroLength = (size == 2'd0);  // Status stage
   assign lastByte     = (count + 2'd1 == size);

   always_ff @(posedge USB_Clk) begin
      if (softReset) begin
         size       <= 2'd0;
         count      <= 2'd0;
         inSequence <= 1'b0;
      end else begin
         if (inAck) inSequence <= !inSequence;
         if (loadResponse) begin
            size       <= responseSize;
            count      <= 2'd0;
            inSequence <= 1'b1;   // First IN after SETUP is DATA1
         end else if (take) begin
            count <= count + 2'd1;
         end
      end
   end

   // Payload shift, held during wait-request
   always_ff @(posedge USB_Clk) begin
      if (loadResponse) shiftReg <= responseValue;
      else if (take)    shiftReg <= {8'h00, shiftReg[15:8]};
   end

endmodule

`default_nettype wire

/* audio/sampleFifo.sv */
`default_nettype none

module sampleFifo (
   input  wire         USB_Clk,
   input  wire         softReset,
   input  wire         altSetting,
   input  wire  [3:0]  endpoint,
   input  wire         outValid,
   input  wire         outEoP,
   input  wire  [7:0]  outData,
   input  wire         sampleStrobe,
   output logic [31:0] sampleWord        // {right, left}
);
   import usbAudioPkg::*;

   logic [31:0] mem [0:(2**FIFO_ADDR_BITS)/4-1];
   logic [FIFO_ADDR_BITS-1:0] writeAddr;    // Byte address
   logic [FIFO_ADDR_BITS-3:0] readAddr;     // Word address
   logic [7:0]  writeByte;
   logic        writePending;
   logic        eopPending;
   logic        audioPacket;
   logic        clear;
   logic        playing;

   assign audioPacket = altSetting && (endpoint == AUDIO_ENDPOINT) && outValid;
   assign clear       = softReset || !altSetting;

   // ------------------------------
   // Write side
   // ------------------------------
   always_ff @(posedge USB_Clk) begin
      writeByte <= outData;
      if (clear) begin
         writePending <= 1'b0;
         eopPending   <= 1'b0;
      end else begin
         writePending <= audioPacket && !outEoP;
         eopPending   <= audioPacket && outEoP;
      end
   end

   always_ff @(posedge USB_Clk) begin
      if (writePending)
         mem[writeAddr[FIFO_ADDR_BITS-1:2]][{writeAddr[1:0], 3'b000} +: 8] <= writeByte;
   end

   always_ff @(posedge USB_Clk) begin
      if (clear) begin
         writeAddr  <= '0;
         readAddr   <= '0;
         playing    <= 1'b0;
         sampleWord <= '0;   // Silence at midpoint
      end else begin
         if (writePending)    writeAddr <= writeAddr + 1'b1;
         else if (eopPending) writeAddr[1:0] <= 2'b00;   // Realign after a lost byte
         if (writeAddr == FIFO_PREFILL) playing <= 1'b1;
         if (playing && sampleStrobe) begin
            sampleWord <= mem[readAddr];
            readAddr   <= readAddr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* audio/audioPwm.sv */
`default_nettype none

module audioPwm (
   input  wire         USB_Clk,
   input  wire         softReset,
   input  wire         mute,
   input  wire  [31:0] sampleWord,
   output logic        sampleStrobe,
   output logic [1:0]  audio
);
   import usbAudioPkg::*;

   logic [31:0] phase;      // 48 kHz accumulator
   logic        phaseMsb;
   logic [9:0]  pwmCount;
   logic [9:0]  leftDuty;
   logic [9:0]  rightDuty;
   logic        leftPwm;
   logic        rightPwm;

   assign sampleStrobe = phase[31] && !phaseMsb;   // Rising MSB

   always_ff @(posedge USB_Clk) begin
      if (softReset) begin
         phase     <= '0;
         phaseMsb  <= 1'b0;
         pwmCount  <= '0;
         leftDuty  <= '0;
         rightDuty <= '0;
         leftPwm   <= 1'b0;
         rightPwm  <= 1'b0;
      end else begin
         phase    <= phase + SAMPLE_INCREMENT;
         phaseMsb <= phase[31];
         if (sampleStrobe) begin
            // Top 9 bits of the sample, signed, around the midpoint
            leftDuty  <= {sampleWord[15], sampleWord[15:7]} + PWM_MIDPOINT;
            rightDuty <= {sampleWord[31], sampleWord[31:23]} + PWM_MIDPOINT;
            pwmCount  <= '0;
         end else begin
            pwmCount <= pwmCount + 10'd1;
         end
         leftPwm  <= (leftDuty > pwmCount);
         rightPwm <= (rightDuty > pwmCount);
      end
   end

   assign audio = mute ? 2'b00 : {leftPwm, rightPwm};

endmodule

`default_nettype wire

/* hdl/usbAudioFunction.sv */
`default_nettype none

module usbAudioFunction (
   input  wire        USB_Clk,
   input  wire        rst,
   // Transceiver side
   input  wire  [3:0] endpoint,
   input  wire        outSetup,
   input  wire        outSoP,
   input  wire        outEoP,
   input  wire  [7:0] outData,
   input  wire        outValid,
   input  wire        inWaitRequest,
   input  wire        inAck,
   input  wire        error,
   input  wire        resetRequest,
   output logic [6:0] address,
   output logic       stall,
   output logic [7:0] inData,
   output logic       inReady,
   output logic       inZeroLength,
   output logic       inSequence,
   output logic       outWaitRequest,
   output logic [1:0] audio             // {left, right} PWM
);
   import usbAudioPkg::*;

   logic        softReset;
   logic        writeMute;
   logic        writeVolumeLeft;
   logic        writeVolumeRight;
   logic        writeAltSetting;
   logic [15:0] writeValue;
   logic        loadResponse;
   logic [15:0] responseValue;
   logic [1:0]  responseSize;
   requestCodeT requestCode;
   logic [7:0]  controlSelect;
   logic [7:0]  channelSelect;
   logic [15:0] target;
   logic [15:0] getValue;
   logic        getValid;
   logic        lastByte;
   logic        mute;
   logic        altSetting;
   logic        sampleStrobe;
   logic [31:0] sampleWord;

   // Bus reset from the host counts as a full reset
   always_ff @(posedge USB_Clk) begin
      softReset <= rst || resetRequest;
   end

   assign outWaitRequest = (endpoint > AUDIO_ENDPOINT);   // Only EP0 and EP1 take data

   setupControl    setupControlInst (.*);
   featureUnitRegs featureUnitRegsInst (.*);
   inResponder     inResponderInst (.*);
   sampleFifo      sampleFifoInst (.*);
   audioPwm        audioPwmInst (.*);

endmodule

`default_nettype wire

/* verif/usbAudioFunctionTb.sv */
`default_nettype none

module usbAudioFunctionTb;
   timeunit 1ns;
   timeprecision 100ps;
   import usbAudioPkg::*;

   logic       USB_Clk;
   logic       rst;
   logic [3:0] endpoint;
   logic       outSetup;
   logic       outSoP;
   logic       outEoP;
   logic [7:0] outData;
   logic       outValid;
   logic       inWaitRequest;
   logic       inAck;
   logic       error;
   logic       resetRequest;
   logic [6:0] address;
   logic       stall;
   logic [7:0] inData;
   logic       inReady;
   logic       inZeroLength;
   logic       inSequence;
   logic       outWaitRequest;
   logic [1:0] audio;

   int errors = 0;
   int checks = 0;
   int seed   = 32'h8882b304;   // Fixed seed, repeatable run

   usbAudioFunction dut_i (.*);

   initial begin
      USB_Clk = 1'b0;
      forever #2 USB_Clk = ~USB_Clk;   // 4 ns period
   end

   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got %h expected %h", name, got, exp);
      end
   endtask

   // ------------------------------
   // Bus level helpers
   // ------------------------------
   task automatic driveByte(input logic [3:0] ep, input logic [7:0] data,
                            input logic sop, input logic setup, input logic eop);
      endpoint = ep;
      outData  = data;
      outValid = 1'b1;
      outSoP   = sop;
      outSetup = setup;
      outEoP   = eop;
      @(negedge USB_Clk);
   endtask

   task automatic releaseBus;
      outValid = 1'b0;
      outSoP   = 1'b0;
      outSetup = 1'b0;
      outEoP   = 1'b0;
      endpoint = 4'd0;
      @(negedge USB_Clk);   // Dispatch done by now
   endtask

   // Eight SETUP bytes, then the EoP cycle
   task automatic sendSetup(input logic [7:0] reqType, input logic [7:0] req,
                            input logic [15:0] value, input logic [15:0] index);
      driveByte(4'd0, reqType, 1'b1, 1'b1, 1'b0);
      driveByte(4'd0, req, 1'b0, 1'b0, 1'b0);
      driveByte(4'd0, value[7:0], 1'b0, 1'b0, 1'b0);
      driveByte(4'd0, value[15:8], 1'b0, 1'b0, 1'b0);
      driveByte(4'd0, index[7:0], 1'b0, 1'b0, 1'b0);
      driveByte(4'd0, index[15:8], 1'b0, 1'b0, 1'b0);
      driveByte(4'd0, 8'h02, 1'b0, 1'b0, 1'b0);   // wLength
      driveByte(4'd0, 8'h00, 1'b0, 1'b0, 1'b0);
      driveByte(4'd0, 8'h00, 1'b0, 1'b0, 1'b1);   // CRC slot carries EoP
      releaseBus();
   endtask

   // OUT packet, bytes cycle through the word LSB first; count 0 is a status stage
   task automatic sendOut(input logic [3:0] ep, input logic [31:0] word, input int count);
      for (int i = 0; i < count; i++) begin
         driveByte(ep, word[8*(i%4) +: 8], i == 0, 1'b0, 1'b0);
      end
      driveByte(ep, 8'h00, count == 0, 1'b0, 1'b1);
      releaseBus();
   endtask

   task automatic waitInReady(input string what);
      int t;
      t = 0;
      while (!inReady && t < 100) begin
         @(negedge USB_Clk);
         t++;
      end
      if (t >= 100) begin
         errors++;
         $display("Timeout waiting for inReady during %s", what);
      end
   endtask

   task automatic pulseAck;
      inAck = 1'b1;
      @(negedge USB_Clk);
      inAck = 1'b0;
      @(negedge USB_Clk);
   endtask

   task automatic doStatusIn;
      waitInReady("status IN");
      checkValue("inZeroLength", inZeroLength, 1'b1);   // Empty status packet
      pulseAck();
      checkValue("inReady", inReady, 1'b0);
   endtask

   // Reads n IN bytes, acks the packet and checks the toggle
   task automatic readIn(input int n, output logic [15:0] value);
      logic seq;
      value = 16'h0000;
      seq   = 1'b0;
      for (int i = 0; i < n; i++) begin
         waitInReady("data IN");
         if (i == 0) seq = inSequence;
         checkValue("inZeroLength", inZeroLength, 1'b0);
         value[8*i +: 8] = inData;
         @(negedge USB_Clk);   // Byte taken on this edge
      end
      checkValue("inReady", inReady, 1'b0);
      pulseAck();
      checkValue("inSequence", inSequence, !seq);   // One toggle per ack
   endtask

   // ------------------------------
   // Request level helpers
   // ------------------------------
   task automatic classGet(input logic [7:0] req, input logic [15:0] value,
                           input int n, output logic [15:0] result);
      sendSetup(8'hA1, req, value, 16'h0002);
      readIn(n, result);
      sendOut(4'd0, 32'h0, 0);   // Status OUT
   endtask

   task automatic classSet(input logic [15:0] value, input logic [15:0] data, input int n);
      sendSetup(8'h21, SET_CUR, value, 16'h0002);
      sendOut(4'd0, {16'h0, data}, n);
      doStatusIn();
   endtask

   task automatic waitStrobe;
      int t;
      t = 0;
      while (!dut_i.sampleStrobe && t < 2500) begin
         @(negedge USB_Clk);
         t++;
      end
      if (t >= 2500) begin
         errors++;
         $display("Timeout waiting for the sample strobe");
      end
      @(negedge USB_Clk);
   endtask

   task automatic measureDuty(input logic [31:0] word);
      int highL;
      int highR;
      int expL;
      int expR;
      int t;
      highL = 0;
      highR = 0;
      t     = 0;
      expL  = ($signed({{16{word[15]}}, word[15:0]}) >>> 7) + 500;    // Midpoint offset
      expR  = ($signed({{16{word[31]}}, word[31:16]}) >>> 7) + 500;
      while (!dut_i.sampleStrobe && t < 2500) begin
         highL += audio[1];
         highR += audio[0];
         @(negedge USB_Clk);
         t++;
      end
      if (t >= 2500) begin
         errors++;
         $display("Timeout measuring one PWM period");
      end
      if (highL - expL > 2 || expL - highL > 2) checkValue("audio[1] high", highL, expL);
      if (highR - expR > 2 || expR - highR > 2) checkValue("audio[0] high", highR, expR);
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic checkResetState;
      checkValue("address", address, 7'h00);
      checkValue("stall", stall, 1'b0);
      checkValue("inReady", inReady, 1'b0);
      checkValue("inSequence", inSequence, 1'b0);
      checkValue("audio", audio, 2'b00);
   endtask

   task automatic assignAddress;
      sendSetup(8'h00, SET_ADDRESS, 16'h0025, 16'h0000);
      doStatusIn();
      checkValue("address", address, 7'h25);
   endtask

   task automatic exerciseVolume;
      logic [15:0] result;
      logic [15:0] randomVolume;
      classGet(GET_CUR, 16'h0201, 2, result);
      checkValue("volumeLeft", result, 16'h1400);   // 20 dB
      randomVolume = $random(seed);
      classSet(16'h0201, randomVolume, 2);
      classGet(GET_CUR, 16'h0201, 2, result);
      checkValue("volumeLeft", result, randomVolume);
      classGet(GET_MIN, 16'h0202, 2, result);
      checkValue("volumeMin", result, 16'h0000);
      classGet(GET_MAX, 16'h0202, 2, result);
      checkValue("volumeMax", result, 16'h7FFF);
      classGet(GET_RES, 16'h0201, 2, result);
      checkValue("volumeRes", result, 16'h0001);
   endtask

   task automatic muteOutputs;
      logic [15:0] result;
      classSet(16'h0100, 16'h0001, 1);   // Mute on
      classGet(GET_CUR, 16'h0100, 1, result);
      checkValue("mute", result, 16'h0001);
      for (int i = 0; i < 1100; i++) begin
         if (audio !== 2'b00) checkValue("audio", audio, 2'b00);
         @(negedge USB_Clk);
      end
      classSet(16'h0100, 16'h0000, 1);   // Mute off again
   endtask

   task automatic provokeStall;
      sendSetup(8'h80, GET_DESCRIPTOR, 16'h0100, 16'h0000);
      checkValue("stall", stall, 1'b1);
      sendSetup(8'h21, SET_CUR, 16'h0201, 16'h0502);   // Unit 5, right interface
      checkValue("stall", stall, 1'b0);
      sendOut(4'd0, 32'h0000_1234, 2);
      checkValue("stall", stall, 1'b1);
      sendSetup(8'h00, SET_ADDRESS, 16'h0025, 16'h0000);
      checkValue("stall", stall, 1'b0);
      doStatusIn();
   endtask

   task automatic sweepEndpoints;
      for (int ep = 0; ep < 16; ep++) begin
         endpoint = ep[3:0];
         @(negedge USB_Clk);
         checkValue("outWaitRequest", outWaitRequest, ep >= 2);
      end
      endpoint = 4'd0;
      @(negedge USB_Clk);
   endtask

   task automatic playStream;
      logic [31:0] stereoWord;
      sendSetup(8'h01, SET_INTERFACE, 16'h0001, 16'h0001);
      doStatusIn();
      stereoWord = $random(seed);
      for (int p = 0; p < 10; p++) begin
         sendOut(4'd1, stereoWord, 40);   // 10 packets, 400 bytes
      end
      repeat (3) waitStrobe();   // Word latched, then duty loaded
      measureDuty(stereoWord);
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      rst = 1'b1;
      endpoint = 4'd0;
      outSetup = 1'b0;
      outSoP = 1'b0;
      outEoP = 1'b0;
      outData = 8'h00;
      outValid = 1'b0;
      inWaitRequest = 1'b0;
      inAck = 1'b0;
      error = 1'b0;
      resetRequest = 1'b0;
      repeat (8) @(negedge USB_Clk);
      rst = 1'b0;
      repeat (2) @(negedge USB_Clk);   // softReset lags one cycle

      checkResetState();
      assignAddress();
      exerciseVolume();
      muteOutputs();
      provokeStall();
      sweepEndpoints();
      playStream();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* usbAudioFunction.f */
common/usbAudioPkg.sv
control/setupControl.sv
control/featureUnitRegs.sv
control/inResponder.sv
audio/sampleFifo.sv
audio/audioPwm.sv
hdl/usbAudioFunction.sv
verif/usbAudioFunctionTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= usbAudioFunctionTb
FLIST     ?= usbAudioFunction.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD) -o simv
	./$(BUILD)/simv > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
